// ==== source/tbird_pkg.sv ====
package tbird_pkg;

    // Display geometry, per side
    parameter int digits = 3;                    // Digits per side
    parameter int segments = 6;                  // Segments used in each digit
    parameter int sweep_steps = digits * segments;  // Steps in one turn sweep

    // Sweep position 0 to sweep_steps-1
    typedef logic [4:0] step_t;

    // Controller mode
    typedef enum logic [1:0] {
        rest       = 2'd0,                       // All dark, waiting for a button
        right_turn = 2'd1,                       // Sweeping the right side
        left_turn  = 2'd2,                       // Sweeping the left side
        hazard     = 2'd3                        // Both sides fully lit for one step
    } mode_t;

    // Selects which side a display block drives
    typedef enum logic {
        right_side = 1'b0,
        left_side  = 1'b1
    } side_t;

    // Bit k is the lamp of digit k, 1 is lit
    typedef logic [digits-1:0] lamp_bar_t;

    // One digit, one bit per segment
    typedef logic [segments-1:0] digit_segments_t;

    // All digits of one side, active low (0 is lit)
    typedef digit_segments_t [digits-1:0] side_segments_t;

endpackage

// ==== source/blink_timer.sv ====
`timescale 1ns/10ps

module blink_timer #(
    parameter int TICK_DIVIDE = 25000000         // Clock cycles per step
) (
    input  logic clock,
    input  logic reset,                          // Synchronous, active low
    output logic step_tick                       // One cycle pulse per step
);

    // A divide of 1 would give a zero width counter
    localparam int count_width = (TICK_DIVIDE > 1) ? $clog2(TICK_DIVIDE) : 1;
    localparam logic [count_width-1:0] count_last = count_width'(TICK_DIVIDE - 1);

    logic [count_width-1:0] count;

    always_ff @(posedge clock) begin
        if (!reset) begin
            count <= '0;
        end else if (count == count_last) begin
            count <= '0;                         // Wrap, start next step
        end else begin
            count <= count + 1'b1;
        end
    end

    // Pulse on the last count of each period; count is cleared in reset,
    // so the first pulse lands TICK_DIVIDE cycles after release
    assign step_tick = (count == count_last);

endmodule

// ==== source/turn_sequencer.sv ====
`timescale 1ns/10ps

module turn_sequencer (
    input  logic              clock,
    input  logic              reset,             // Synchronous, active low
    input  logic              step_tick,         // Advance enable from the blink timer
    input  logic              right_button,      // Active low
    input  logic              left_button,       // Active low
    input  logic              hazard_button,     // Active low
    output tbird_pkg::mode_t  mode,
    output tbird_pkg::step_t  step
);

    localparam tbird_pkg::step_t last_step = tbird_pkg::step_t'(tbird_pkg::sweep_steps - 1);

    tbird_pkg::mode_t mode_q;
    tbird_pkg::mode_t mode_next;
    tbird_pkg::step_t step_q;
    tbird_pkg::step_t step_next;

    // Next mode and step, applied only on a tick
    always_comb begin
        mode_next = mode_q;
        step_next = step_q;

        case (mode_q)
            tbird_pkg::rest: begin
                step_next = '0;
                if (!right_button) begin
                    mode_next = tbird_pkg::right_turn;   // Right wins over left
                end else if (!left_button) begin
                    mode_next = tbird_pkg::left_turn;    // Left wins over hazard
                end else if (!hazard_button) begin
                    mode_next = tbird_pkg::hazard;
                end else begin
                    mode_next = tbird_pkg::rest;
                end
            end

            tbird_pkg::right_turn,
            tbird_pkg::left_turn: begin
                if (!hazard_button) begin
                    mode_next = tbird_pkg::hazard;       // Hazard cuts the sweep short
                    step_next = '0;
                end else if (step_q == last_step) begin
                    mode_next = tbird_pkg::rest;         // Sweep done
                    step_next = '0;
                end else begin
                    step_next = step_q + 1'b1;
                end
            end

            tbird_pkg::hazard: begin
                // One lit step, then dark again; held button makes it blink
                mode_next = tbird_pkg::rest;
                step_next = '0;
            end

            default: begin
                mode_next = tbird_pkg::rest;
                step_next = '0;
            end
        endcase
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            mode_q <= tbird_pkg::rest;
            step_q <= '0;
        end else if (step_tick) begin
            mode_q <= mode_next;
            step_q <= step_next;
        end
    end

    assign mode = mode_q;
    assign step = step_q;

endmodule

// ==== source/side_display.sv ====
`timescale 1ns/10ps

module side_display #(
    parameter tbird_pkg::side_t SIDE = tbird_pkg::right_side    // Side this block drives
) (
    input  tbird_pkg::mode_t          mode,
    input  tbird_pkg::step_t          step,
    output tbird_pkg::lamp_bar_t      lamps,     // Active high
    output tbird_pkg::side_segments_t segments   // Active low
);

    localparam tbird_pkg::mode_t own_turn =
        (SIDE == tbird_pkg::right_side) ? tbird_pkg::right_turn : tbird_pkg::left_turn;

    logic hazard_on;
    logic sweeping;

    assign hazard_on = (mode == tbird_pkg::hazard);
    assign sweeping  = (mode == own_turn);       // Only the matching turn sweeps here

    // Thermometer fill, digit by digit then segment by segment
    always_comb begin
        int first_step;

        first_step = 0;
        lamps = '0;
        segments = '1;                           // Dark by default

        for (int k = 0; k < tbird_pkg::digits; k++) begin
            first_step = k * tbird_pkg::segments;
            lamps[k] = hazard_on || (sweeping && (int'(step) >= first_step));

            for (int s = 0; s < tbird_pkg::segments; s++) begin
                segments[k][s] = !(hazard_on ||
                                   (sweeping && (int'(step) >= first_step + s)));
            end
        end
    end

endmodule

// ==== source/tbird_lights.sv ====
`timescale 1ns/10ps

module tbird_lights #(
    parameter int TICK_DIVIDE = 25000000         // Clock cycles per step
) (
    input  logic                      clock,
    input  logic                      reset,     // Synchronous, active low
    input  logic                      right_button,
    input  logic                      left_button,
    input  logic                      hazard_button,
    output tbird_pkg::lamp_bar_t      right_lamps,
    output tbird_pkg::side_segments_t right_segments,
    output tbird_pkg::lamp_bar_t      left_lamps,
    output tbird_pkg::side_segments_t left_segments
);

    logic             step_tick;
    tbird_pkg::mode_t mode;
    tbird_pkg::step_t step;

    blink_timer #(
        .TICK_DIVIDE (TICK_DIVIDE)
    ) blink_timer0 (
        .clock     (clock),
        .reset     (reset),
        .step_tick (step_tick)
    );

    turn_sequencer turn_sequencer0 (
        .clock         (clock),
        .reset         (reset),
        .step_tick     (step_tick),
        .right_button  (right_button),
        .left_button   (left_button),
        .hazard_button (hazard_button),
        .mode          (mode),
        .step          (step)
    );

    // Same decoder on both sides, only the side differs
    side_display #(
        .SIDE (tbird_pkg::right_side)
    ) right_display (
        .mode     (mode),
        .step     (step),
        .lamps    (right_lamps),
        .segments (right_segments)
    );

    side_display #(
        .SIDE (tbird_pkg::left_side)
    ) left_display (
        .mode     (mode),
        .step     (step),
        .lamps    (left_lamps),
        .segments (left_segments)
    );

endmodule

// ==== tb/tbird_checks.svh ====
`ifndef TBIRD_CHECKS_SVH
`define TBIRD_CHECKS_SVH

int check_count = 0;
int lamp_errors = 0;                             // Lamp mismatches
int segment_errors = 0;                          // Segment mismatches

task automatic check_lamps(
    input string                name,
    input tbird_pkg::lamp_bar_t expected,
    input tbird_pkg::lamp_bar_t actual
);
    check_count++;
    if (actual !== expected) begin
        lamp_errors++;
        $display("[FAIL] %s: expected %b, actual %b (at %0t)",
                 name, expected, actual, $time);
    end
endtask

task automatic check_segments(
    input string                     name,
    input tbird_pkg::side_segments_t expected,
    input tbird_pkg::side_segments_t actual
);
    check_count++;
    if (actual !== expected) begin
        segment_errors++;
        $display("[FAIL] %s: expected %b, actual %b (at %0t)",
                 name, expected, actual, $time);
    end
endtask

`endif

// ==== tb/tbird_lights_tb.sv ====
`timescale 1ns/10ps

module tbird_lights_tb;

    localparam int tick_divide = 4;              // Short steps for simulation

    // One table row: button and reset levels, step count, lamps expected at the end
    typedef struct packed {
        logic                 right_level;
        logic                 left_level;
        logic                 hazard_level;
        logic                 reset_level;
        int                   steps;
        tbird_pkg::lamp_bar_t right_end;
        tbird_pkg::lamp_bar_t left_end;
    } row_t;

    logic                      clock;
    logic                      reset;
    logic                      right_button;
    logic                      left_button;
    logic                      hazard_button;
    tbird_pkg::lamp_bar_t      right_lamps;
    tbird_pkg::side_segments_t right_segments;
    tbird_pkg::lamp_bar_t      left_lamps;
    tbird_pkg::side_segments_t left_segments;

    row_t             rows[$];
    string            names[$];
    int               total_steps = 0;
    int               timeout_limit = 0;         // Set once the table is built
    int               cycle_count = 0;
    tbird_pkg::mode_t model_mode;
    int               model_step;

    `include "tbird_checks.svh"

    tbird_lights #(
        .TICK_DIVIDE (tick_divide)
    ) dut0 (
        .clock          (clock),
        .reset          (reset),
        .right_button   (right_button),
        .left_button    (left_button),
        .hazard_button  (hazard_button),
        .right_lamps    (right_lamps),
        .right_segments (right_segments),
        .left_lamps     (left_lamps),
        .left_segments  (left_segments)
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
    end

    initial begin
        wait (timeout_limit > 0 && cycle_count >= timeout_limit);
        $display("Timeout: the run did not finish within %0d clock cycles", timeout_limit);
        $display("Test failures found");
        $finish;
    end

    task automatic add_row(
        input string                name,
        input logic                 right_level,
        input logic                 left_level,
        input logic                 hazard_level,
        input logic                 reset_level,
        input int                   steps,
        input tbird_pkg::lamp_bar_t right_end,
        input tbird_pkg::lamp_bar_t left_end
    );
        row_t row;
        row.right_level = right_level;
        row.left_level = left_level;
        row.hazard_level = hazard_level;
        row.reset_level = reset_level;
        row.steps = steps;
        row.right_end = right_end;
        row.left_end = left_end;
        rows.push_back(row);
        names.push_back(name);
        total_steps += steps;
    endtask

    // Buttons and reset are active low; 1 means released
    task automatic build_table();
        add_row("idle_after_reset", 1, 1, 1, 1, 3,  3'b000, 3'b000);
        add_row("right_press",      0, 1, 1, 1, 1,  3'b001, 3'b000);
        add_row("right_sweep",      1, 1, 1, 1, 17, 3'b111, 3'b000);
        add_row("right_done",       1, 1, 1, 1, 2,  3'b000, 3'b000);
        add_row("left_press",       1, 0, 1, 1, 1,  3'b000, 3'b001);
        add_row("left_sweep",       1, 1, 1, 1, 18, 3'b000, 3'b000);
        add_row("right_over_left",  0, 0, 1, 1, 1,  3'b001, 3'b000);
        add_row("right_partial",    1, 1, 1, 1, 10, 3'b011, 3'b000);
        add_row("hazard_mid_sweep", 1, 1, 0, 1, 1,  3'b111, 3'b111);
        add_row("hazard_done",      1, 1, 1, 1, 1,  3'b000, 3'b000);
        add_row("hazard_hold",      1, 1, 0, 1, 5,  3'b111, 3'b111);
        add_row("hazard_release",   1, 1, 1, 1, 2,  3'b000, 3'b000);
        add_row("left_again",       1, 0, 1, 1, 1,  3'b000, 3'b001);
        add_row("left_partial",     1, 1, 1, 1, 8,  3'b000, 3'b011);
        add_row("reset_mid_sweep",  1, 1, 1, 0, 1,  3'b000, 3'b000);
        add_row("left_restart",     1, 0, 1, 1, 1,  3'b000, 3'b001);
        add_row("left_resume",      1, 1, 1, 1, 6,  3'b000, 3'b011);
        add_row("left_finish",      1, 1, 1, 1, 13, 3'b000, 3'b000);
    endtask

    task automatic clear_model();
        model_mode = tbird_pkg::rest;
        model_step = 0;
    endtask

    // One step of the turn sequencer, taken on a tick edge
    task automatic advance_model(input logic right_n, input logic left_n, input logic hazard_n);
        case (model_mode)
            tbird_pkg::rest: begin
                model_step = 0;
                if (!right_n) begin
                    model_mode = tbird_pkg::right_turn;
                end else if (!left_n) begin
                    model_mode = tbird_pkg::left_turn;
                end else if (!hazard_n) begin
                    model_mode = tbird_pkg::hazard;
                end
            end
            tbird_pkg::right_turn, tbird_pkg::left_turn: begin
                if (!hazard_n) begin
                    model_mode = tbird_pkg::hazard;
                    model_step = 0;
                end else if (model_step == tbird_pkg::sweep_steps - 1) begin
                    clear_model();
                end else begin
                    model_step++;
                end
            end
            tbird_pkg::hazard: begin
                clear_model();
            end
        endcase
    endtask

    // How many segments of a side are lit, counted along the sweep
    function automatic int lit_segments(input tbird_pkg::side_t side);
        if (model_mode == tbird_pkg::hazard) begin
            return tbird_pkg::sweep_steps;
        end
        if (model_mode == tbird_pkg::right_turn && side == tbird_pkg::right_side) begin
            return model_step + 1;
        end
        if (model_mode == tbird_pkg::left_turn && side == tbird_pkg::left_side) begin
            return model_step + 1;
        end
        return 0;
    endfunction

    function automatic tbird_pkg::lamp_bar_t expected_lamps(input int lit);
        tbird_pkg::lamp_bar_t bar;
        bar = '0;
        for (int k = 0; k < tbird_pkg::digits; k++) begin
            bar[k] = (lit > k * tbird_pkg::segments);  // Lamp on once its digit starts
        end
        return bar;
    endfunction

    function automatic tbird_pkg::side_segments_t expected_segments(input int lit);
        logic [tbird_pkg::sweep_steps-1:0] flat;
        flat = '1;
        for (int i = 0; i < lit; i++) begin
            flat[i] = 1'b0;                      // Low is lit
        end
        return flat;
    endfunction

    task automatic compare_outputs(input string name);
        int right_lit;
        int left_lit;
        right_lit = lit_segments(tbird_pkg::right_side);
        left_lit = lit_segments(tbird_pkg::left_side);
        check_lamps({name, " right lamps"}, expected_lamps(right_lit), right_lamps);
        check_segments({name, " right segments"}, expected_segments(right_lit), right_segments);
        check_lamps({name, " left lamps"}, expected_lamps(left_lit), left_lamps);
        check_segments({name, " left segments"}, expected_segments(left_lit), left_segments);
    endtask

    // Called 1 ns after an edge; the last edge of each step is the tick edge
    task automatic apply_row(input int index);
        row_t  row;
        string name;
        row = rows[index];
        name = names[index];
        for (int n = 0; n < row.steps; n++) begin
            right_button = row.right_level;
            left_button = row.left_level;
            hazard_button = row.hazard_level;
            reset = row.reset_level;
            for (int c = 1; c <= tick_divide; c++) begin
                @(posedge clock);
                #1;
                if (!row.reset_level) begin
                    clear_model();               // Reset wins on every edge
                end else if (c == tick_divide) begin
                    advance_model(row.right_level, row.left_level, row.hazard_level);
                end
                compare_outputs(name);
            end
        end
        check_lamps({name, " end right lamps"}, row.right_end, right_lamps);
        check_lamps({name, " end left lamps"}, row.left_end, left_lamps);
    endtask

    initial begin
        reset = 1'b0;
        right_button = 1'b1;
        left_button = 1'b1;
        hazard_button = 1'b1;
        build_table();
        timeout_limit = total_steps * tick_divide + 50;
        clear_model();

        repeat (3) @(posedge clock);             // Reset held for 3 cycles
        #1;

        for (int r = 0; r < rows.size(); r++) begin
            apply_row(r);
        end

        $display("Checks: %0d, lamp errors: %0d, segment errors: %0d",
                 check_count, lamp_errors, segment_errors);
        if (lamp_errors == 0 && segment_errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// ==== tbird_lights.f ====
+incdir+tb
source/tbird_pkg.sv
source/blink_timer.sv
source/turn_sequencer.sv
source/side_display.sv
source/tbird_lights.sv
tb/tbird_lights_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the tail-light testbench with Verilator, run it, and check for the pass message
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tbird_lights_tb -f tbird_lights.f \
    -o tbird_lights_sim || { echo "Verilator build failed"; exit 1; }

sim_output=$(./obj_dir/tbird_lights_sim)
printf '%s\n' "$sim_output"

printf '%s\n' "$sim_output" | grep -q "All tests passed!" && exit 0 || exit 1
